// ==== list.f ====
hdl/mips_pkg.sv
hdl/reg_file.sv
hdl/instr_decoder.sv
hdl/hazard_check.sv
hdl/branch_unit.sv
hdl/id_stage.sv
bench/clock_gen.sv
bench/tb_id_stage.sv

// ==== bench/tb_id_stage.sv ====
// directed testbench for the decode stage
// reference register model, instruction encoders, check task
// tests: register reads, immediates, next pc, stall, back-pressure
`timescale 1ns/1ps
`default_nettype none

module tb_id_stage;

    localparam int max_cycles = 600;   // about three times the test length

    logic                    clk;
    logic                    rst_n;
    logic                    if_valid;
    mips_pkg::fetch_bundle_t fetch;
    logic [31:0]             fetch_npc_fast;
    logic                    exe_allowin;
    mips_pkg::wb_write_t     wb_write;
    mips_pkg::stage_write_t  exe_status;
    mips_pkg::stage_write_t  mem_status;
    mips_pkg::stage_write_t  wb_status;
    logic                    id_allowin;
    logic                    id_valid;
    mips_pkg::exe_bundle_t   exe_out;
    logic [31:0]             next_pc;

    logic [31:0] ref_regs [0:31];   // mirrors every wb write
    integer      seed = 32'hcde0;
    int          cycles = 0;

    clock_gen u_clk (
        .clk   (clk),
        .rst_n (rst_n)
    );

    id_stage uut (
        .clk            (clk),
        .rst_n          (rst_n),
        .if_valid       (if_valid),
        .fetch          (fetch),
        .fetch_npc_fast (fetch_npc_fast),
        .id_allowin     (id_allowin),
        .exe_allowin    (exe_allowin),
        .id_valid       (id_valid),
        .exe            (exe_out),
        .wb_write       (wb_write),
        .exe_status     (exe_status),
        .mem_status     (mem_status),
        .wb_status      (wb_status),
        .next_pc        (next_pc)
    );

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= max_cycles) begin
            $display("Verification failed");
            $fatal(1, "timeout after %0d cycles, the DUT never finished the tests", cycles);
        end
    end

    // ------------------------------------------------------------------------
    // helpers
    // ------------------------------------------------------------------------
    task automatic check_value(input string name, input logic [191:0] expected,
                               input logic [191:0] actual);
        if (actual !== expected) begin
            $display("ERROR at %0t ns: %s expected %0h, got %0h",
                     $time, name, expected, actual);
            $display("Verification failed");
            $fatal(1, "stopping at the first mismatch");
        end
    endtask

    function automatic logic [31:0] r_type(input logic [4:0] rs, input logic [4:0] rt,
                                           input logic [4:0] rd, input logic [4:0] sa,
                                           input mips_pkg::funct_e fn);
        return {6'h00, rs, rt, rd, sa, fn};
    endfunction

    function automatic logic [31:0] i_type(input mips_pkg::opcode_e op, input logic [4:0] rs,
                                           input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] j_type(input mips_pkg::opcode_e op,
                                           input logic [25:0] index);
        return {op, index};
    endfunction

    // one writeback cycle, model updated by byte lane
    task automatic write_reg(input logic [4:0] num, input logic [31:0] data,
                             input logic [3:0] wen);
        @(posedge clk);
        #1;
        wb_write.wdata = data;
        wb_write.wen   = wen;
        wb_write.wnum  = num;
        if (num != 5'd0) begin
            for (int b = 0; b < 4; b++) begin
                if (wen[b]) ref_regs[num][8*b +: 8] = data[8*b +: 8];
            end
        end
        @(posedge clk);
        #1;
        wb_write.wen = 4'h0;
    endtask

    // offer one bundle, wait for the accepting edge, leave at the next negedge
    task automatic send(input logic [31:0] instr, input logic [31:0] pc);
        @(posedge clk);
        #1;
        if_valid   = 1'b1;
        fetch.pc    = pc;
        fetch.npc   = pc + 32'd4;
        fetch.nnpc  = pc + 32'd8;
        fetch.instr = instr;
        @(negedge clk);
        while (!id_allowin) @(negedge clk);
        @(posedge clk);
        #1;
        if_valid = 1'b0;
        @(negedge clk);
    endtask

    task automatic wait_valid();
        while (!id_valid) @(negedge clk);
    endtask

    // ------------------------------------------------------------------------
    // tests
    // ------------------------------------------------------------------------
    task automatic reset_and_regs();
        logic [4:0] num;
        logic [4:0] prev;
        logic [3:0] wen;
        check_value("id_valid", 0, id_valid);
        check_value("id_allowin", 1, id_allowin);
        for (int r = 1; r < 32; r++) write_reg(5'(r), $random(seed), 4'hf);
        prev = 5'd1;
        for (int i = 0; i < 10; i++) begin
            num = 5'($random(seed));
            wen = (i % 2 == 0) ? 4'($random(seed)) : 4'hf;   // partial lanes too
            write_reg(num, $random(seed), wen);
            send(r_type(num, prev, 5'(i + 1), 5'd0, mips_pkg::fn_addu), 32'h0000_0100);
            wait_valid();
            check_value("exe.alu_a", ref_regs[num], exe_out.alu_a);
            check_value("exe.alu_b", ref_regs[prev], exe_out.alu_b);
            check_value("exe.alu_op", mips_pkg::alu_add, exe_out.alu_op);
            check_value("exe.dest.writes", 1, exe_out.dest.writes);
            check_value("exe.dest.wnum", i + 1, exe_out.dest.wnum);
            send(r_type(5'd0, num, 5'(i + 1), 5'd0, mips_pkg::fn_xor_f), 32'h0000_0104);
            wait_valid();
            check_value("exe.alu_a (r0)", 0, exe_out.alu_a);
            check_value("exe.alu_b", ref_regs[num], exe_out.alu_b);
            check_value("exe.alu_op", mips_pkg::alu_xor_op, exe_out.alu_op);
            prev = num;
        end
    endtask

    task automatic immediates_and_shifts();
        send(i_type(mips_pkg::op_addiu, 5'd3, 5'd5, 16'hfff0), 32'h0000_0400);
        wait_valid();
        check_value("exe.alu_a", ref_regs[3], exe_out.alu_a);
        check_value("exe.alu_b addiu", 32'hffff_fff0, exe_out.alu_b);
        check_value("exe.dest.wnum", 5, exe_out.dest.wnum);
        send(i_type(mips_pkg::op_andi, 5'd3, 5'd6, 16'h8f0f), 32'h0000_0404);
        wait_valid();
        check_value("exe.alu_b andi", 32'h0000_8f0f, exe_out.alu_b);
        send(i_type(mips_pkg::op_ori, 5'd4, 5'd7, 16'hf00d), 32'h0000_0408);
        wait_valid();
        check_value("exe.alu_b ori", 32'h0000_f00d, exe_out.alu_b);
        send(i_type(mips_pkg::op_lui, 5'd0, 5'd8, 16'h1234), 32'h0000_040c);
        wait_valid();
        check_value("exe.alu_b lui", 32'h1234_0000, exe_out.alu_b);
        check_value("exe.dest.writes", 1, exe_out.dest.writes);
        send(r_type(5'd0, 5'd4, 5'd7, 5'd13, mips_pkg::fn_sll), 32'h0000_0410);
        wait_valid();
        check_value("exe.alu_a sll", 13, exe_out.alu_a);
        check_value("exe.alu_b sll", ref_regs[4], exe_out.alu_b);
        send(i_type(mips_pkg::op_lw, 5'd2, 5'd9, 16'h0010), 32'h0000_0414);
        wait_valid();
        check_value("exe.mem_read", 1, exe_out.mem_read);
        check_value("exe.mem_write", 0, exe_out.mem_write);
        check_value("exe.dest.wnum", 9, exe_out.dest.wnum);
        check_value("exe.alu_b lw", 32'h10, exe_out.alu_b);
        send(i_type(mips_pkg::op_sw, 5'd2, 5'd6, 16'hfffc), 32'h0000_0418);
        wait_valid();
        check_value("exe.mem_write", 1, exe_out.mem_write);
        check_value("exe.store_data", ref_regs[6], exe_out.store_data);
        check_value("exe.dest.writes", 0, exe_out.dest.writes);
        check_value("exe.alu_b sw", 32'hffff_fffc, exe_out.alu_b);
    endtask

    task automatic next_pc_select();
        logic [31:0] pc;
        pc = 32'hb000_0100;
        write_reg(5'd10, 32'h5555_aaaa, 4'hf);
        write_reg(5'd11, 32'h5555_aaab, 4'hf);
        write_reg(5'd12, 32'h5555_aaaa, 4'hf);
        write_reg(5'd13, 32'h0040_0abc, 4'hf);
        send(i_type(mips_pkg::op_beq, 5'd10, 5'd12, 16'hfffe), pc);
        wait_valid();
        // offset of two words back from npc
        check_value("next_pc beq taken", pc + 32'd4 - 32'd8, next_pc);
        send(i_type(mips_pkg::op_beq, 5'd10, 5'd11, 16'hfffe), pc);
        wait_valid();
        check_value("next_pc beq not taken", fetch_npc_fast, next_pc);
        send(i_type(mips_pkg::op_bne, 5'd10, 5'd11, 16'h0020), pc);
        wait_valid();
        check_value("next_pc bne taken", pc + 32'd4 + 32'h80, next_pc);
        send(i_type(mips_pkg::op_bne, 5'd10, 5'd12, 16'h0020), pc);
        wait_valid();
        check_value("next_pc bne not taken", fetch_npc_fast, next_pc);
        send(j_type(mips_pkg::op_j, 26'h012_3456), pc);
        wait_valid();
        check_value("next_pc j", {pc[31:28], 26'h012_3456, 2'b00}, next_pc);
        send(j_type(mips_pkg::op_jal, 26'h3ff_0001), pc);
        wait_valid();
        check_value("next_pc jal", {pc[31:28], 26'h3ff_0001, 2'b00}, next_pc);
        check_value("exe.dest.wnum jal", mips_pkg::link_reg, exe_out.dest.wnum);
        check_value("exe.dest.writes jal", 1, exe_out.dest.writes);
        check_value("exe.nnpc", pc + 32'd8, exe_out.nnpc);
        send(r_type(5'd13, 5'd0, 5'd0, 5'd0, mips_pkg::fn_jr), pc);
        wait_valid();
        check_value("next_pc jr", 32'h0040_0abc, next_pc);
    endtask

    task automatic stall_on_raw();
        // producer of r3 still in exe
        @(posedge clk);
        #1;
        exe_status = {1'b1, 5'd3};
        send(i_type(mips_pkg::op_addiu, 5'd3, 5'd8, 16'h0001), 32'h0000_0800);
        repeat (3) begin
            check_value("id_valid stalled", 0, id_valid);
            check_value("id_allowin stalled", 0, id_allowin);
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        exe_status = {1'b1, 5'd8};   // rt of addiu is not read
        @(negedge clk);
        check_value("id_valid unused rt", 1, id_valid);
        check_value("id_allowin unused rt", 1, id_allowin);
        @(posedge clk);
        #1;
        exe_status = '0;
        wb_status  = {1'b1, 5'd0};   // r0 never stalls
        mem_status = {1'b1, 5'd4};
        send(r_type(5'd0, 5'd4, 5'd2, 5'd0, mips_pkg::fn_addu), 32'h0000_0804);
        check_value("id_valid stalled on rt", 0, id_valid);
        @(posedge clk);
        #1;
        mem_status = '0;
        @(negedge clk);
        check_value("id_valid after clear", 1, id_valid);
        check_value("exe.alu_b", ref_regs[4], exe_out.alu_b);
        @(posedge clk);
        #1;
        wb_status = '0;
    endtask

    task automatic back_pressure();
        mips_pkg::exe_bundle_t held;
        @(posedge clk);
        #1;
        exe_allowin = 1'b0;
        send(r_type(5'd1, 5'd2, 5'd3, 5'd0, mips_pkg::fn_addu), 32'h0000_2000);
        check_value("id_valid", 1, id_valid);
        check_value("id_allowin", 0, id_allowin);
        // addu r3, r1, r2 as it should sit in the stage
        held.pc          = 32'h0000_2000;
        held.nnpc        = 32'h0000_2008;
        held.alu_a       = ref_regs[1];
        held.alu_b       = ref_regs[2];
        held.store_data  = ref_regs[2];   // rt value
        held.alu_op      = mips_pkg::alu_add;
        held.mem_read    = 1'b0;
        held.mem_write   = 1'b0;
        held.dest.writes = 1'b1;
        held.dest.wnum   = 5'd3;
        @(posedge clk);
        #1;
        if_valid    = 1'b1;   // next bundle waits at fetch
        fetch.pc    = 32'h0000_2004;
        fetch.npc   = 32'h0000_2008;
        fetch.nnpc  = 32'h0000_200c;
        fetch.instr = i_type(mips_pkg::op_ori, 5'd5, 5'd6, 16'h00ff);
        repeat (4) begin
            @(negedge clk);
            check_value("exe held", held, exe_out);
            check_value("id_allowin held", 0, id_allowin);
        end
        @(posedge clk);
        #1;
        exe_allowin = 1'b1;
        @(negedge clk);
        while (!id_allowin) @(negedge clk);
        @(posedge clk);
        #1;
        if_valid = 1'b0;
        @(negedge clk);
        check_value("exe.pc next bundle", 32'h0000_2004, exe_out.pc);
        check_value("exe.alu_b ori", 32'h0000_00ff, exe_out.alu_b);
        check_value("id_valid", 1, id_valid);
        @(negedge clk);
        check_value("id_valid empty", 0, id_valid);
        check_value("id_allowin empty", 1, id_allowin);
    endtask

    // ------------------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------------------
    initial begin
        if_valid       = 1'b0;
        fetch          = '0;
        fetch_npc_fast = 32'h0000_9000;
        exe_allowin    = 1'b1;
        wb_write       = '0;
        exe_status     = '0;
        mem_status     = '0;
        wb_status      = '0;
        for (int r = 0; r < 32; r++) ref_regs[r] = '0;
        @(posedge rst_n);
        @(negedge clk);
        reset_and_regs();
        immediates_and_shifts();
        next_pc_select();
        stall_on_raw();
        back_pressure();
        $display("Verification passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== bench/clock_gen.sv ====
// testbench clock and reset
// 8 ns clock, active-low reset held for four rising edges
`timescale 1ns/1ps
`default_nettype none

module clock_gen (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;   // 8 ns period
    end

    initial begin
        rst_n = 1'b0;
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire

// ==== hdl/id_stage.sv ====
// instruction decode stage, top level
// pipeline register with valid/allowin handshake
// register file, decoder, hazard check, branch unit
// operand selection and valid gating of the outputs
`timescale 1ns/1ps
`default_nettype none

module id_stage (
    input  wire                          clk,
    input  wire                          rst_n,
    // fetch side
    input  wire                          if_valid,
    input  wire mips_pkg::fetch_bundle_t fetch,
    input  wire [31:0]                   fetch_npc_fast,
    output logic                         id_allowin,
    // execute side
    input  wire                          exe_allowin,
    output logic                         id_valid,
    output mips_pkg::exe_bundle_t        exe,
    // writeback and pipeline status
    input  wire mips_pkg::wb_write_t     wb_write,
    input  wire mips_pkg::stage_write_t  exe_status,
    input  wire mips_pkg::stage_write_t  mem_status,
    input  wire mips_pkg::stage_write_t  wb_status,
    // redirect to fetch
    output logic [31:0]                  next_pc
);

    logic                   valid_q;
    mips_pkg::fetch_bundle_t fetch_q;   // held bundle
    mips_pkg::decode_ctrl_t ctrl;
    logic [31:0]            rs_value;
    logic [31:0]            rt_value;
    logic                   ready;
    logic                   taken;
    logic [31:0]            target;
    logic [31:0]            alu_a;
    logic [31:0]            alu_b;

    // ------------------------------------------------------------------------
    // handshake and pipeline register
    // ------------------------------------------------------------------------
    assign id_allowin = !valid_q || (ready && exe_allowin);
    assign id_valid   = valid_q && ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else if (id_allowin) begin
            valid_q <= if_valid;   // empties when fetch has nothing
        end
    end

    always_ff @(posedge clk) begin
        if (id_allowin && if_valid) begin
            fetch_q <= fetch;
        end
    end

    // ------------------------------------------------------------------------
    // decode, register read, hazard and branch
    // ------------------------------------------------------------------------
    instr_decoder u_decoder (
        .instr (fetch_q.instr),
        .ctrl  (ctrl)
    );

    reg_file u_reg_file (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr      (wb_write),
        .raddr_a (ctrl.rs),
        .raddr_b (ctrl.rt),
        .rdata_a (rs_value),
        .rdata_b (rt_value)
    );

    hazard_check u_hazard (
        .ctrl       (ctrl),
        .exe_status (exe_status),
        .mem_status (mem_status),
        .wb_status  (wb_status),
        .ready      (ready)
    );

    branch_unit u_branch (
        .ctrl     (ctrl),
        .npc      (fetch_q.npc),
        .rs_value (rs_value),
        .rt_value (rt_value),
        .taken    (taken),
        .target   (target)
    );

    // ------------------------------------------------------------------------
    // operands and outputs
    // ------------------------------------------------------------------------
    assign alu_a = ctrl.alu_a_is_sa ? {27'd0, ctrl.sa} : rs_value;
    assign alu_b = ctrl.alu_b_is_imm ? ctrl.imm_ext : rt_value;

    always_comb begin
        exe.pc          = fetch_q.pc;
        exe.nnpc        = fetch_q.nnpc;   // jal link value
        exe.alu_a       = alu_a;
        exe.alu_b       = alu_b;
        exe.store_data  = rt_value;
        exe.alu_op      = ctrl.alu_op;
        // side effects only from a held instruction
        exe.mem_read    = ctrl.mem_read && valid_q;
        exe.mem_write   = ctrl.mem_write && valid_q;
        exe.dest.writes = ctrl.reg_write && valid_q;
        exe.dest.wnum   = ctrl.dest;
    end

    // redirect only when a valid branch/jump is taken
    assign next_pc = (taken && valid_q) ? target : fetch_npc_fast;

endmodule

`default_nettype wire

// ==== hdl/branch_unit.sv ====
// branch and jump resolution
// beq/bne compare, j/jal/jr always taken, target selection
`timescale 1ns/1ps
`default_nettype none

module branch_unit (
    input  wire mips_pkg::decode_ctrl_t ctrl,
    input  wire [31:0]                  npc,
    input  wire [31:0]                  rs_value,
    input  wire [31:0]                  rt_value,
    output logic                        taken,
    output logic [31:0]                 target
);

    logic        equal;
    logic [31:0] br_target;
    logic [31:0] j_target;

    assign equal = (rs_value == rt_value);

    // ------------------------------------------------------------------------
    // target candidates
    // ------------------------------------------------------------------------
    assign br_target = npc + {ctrl.imm_ext[29:0], 2'b00};   // offset in words
    assign j_target  = {npc[31:28], ctrl.index, 2'b00};     // same 256MB region

    always_comb begin
        case (ctrl.br_kind)
            mips_pkg::br_beq: begin
                taken  = equal;
                target = br_target;
            end
            mips_pkg::br_bne: begin
                taken  = !equal;
                target = br_target;
            end
            mips_pkg::br_jump: begin
                taken  = 1'b1;
                target = j_target;
            end
            mips_pkg::br_jump_reg: begin
                taken  = 1'b1;
                target = rs_value;
            end
            default: begin   // sequential
                taken  = 1'b0;
                target = br_target;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== hdl/hazard_check.sv ====
// read-after-write stall detection
// compares used source registers against exe, mem and wb writers
`timescale 1ns/1ps
`default_nettype none

module hazard_check (
    input  wire mips_pkg::decode_ctrl_t ctrl,
    input  wire mips_pkg::stage_write_t exe_status,
    input  wire mips_pkg::stage_write_t mem_status,
    input  wire mips_pkg::stage_write_t wb_status,
    output logic                        ready
);

    logic stall_rs;
    logic stall_rt;

    // true when any downstream stage will still write reg r
    function automatic logic pending(input logic [4:0] r,
                                     input mips_pkg::stage_write_t s_exe,
                                     input mips_pkg::stage_write_t s_mem,
                                     input mips_pkg::stage_write_t s_wb);
        logic hit;
        hit = (s_exe.writes && s_exe.wnum == r) ||
              (s_mem.writes && s_mem.wnum == r) ||
              (s_wb.writes  && s_wb.wnum  == r);
        return hit && (r != 5'd0);   // r0 never waits
    endfunction

    assign stall_rs = ctrl.use_rs &&
                      pending(ctrl.rs, exe_status, mem_status, wb_status);
    assign stall_rt = ctrl.use_rt &&
                      pending(ctrl.rt, exe_status, mem_status, wb_status);

    // no forwarding, wait until the producer leaves wb
    assign ready = !(stall_rs || stall_rt);

endmodule

`default_nettype wire

// ==== hdl/instr_decoder.sv ====
// instruction decoder for the supported subset
// field extraction, control flags, alu op, next-pc kind
// and immediate extension (sign, zero, upper half)
`timescale 1ns/1ps
`default_nettype none

module instr_decoder (
    input  wire [31:0]             instr,
    output mips_pkg::decode_ctrl_t ctrl
);

    logic [4:0]        rs;
    logic [4:0]        rt;
    logic [4:0]        rd;
    logic [15:0]       imm;
    logic [31:0]       imm_sign;
    logic [31:0]       imm_zero;
    logic [31:0]       imm_upper;
    mips_pkg::opcode_e opcode;
    mips_pkg::funct_e  funct;

    assign rs     = instr[25:21];
    assign rt     = instr[20:16];
    assign rd     = instr[15:11];
    assign imm    = instr[15:0];
    assign opcode = mips_pkg::opcode_e'(instr[31:26]);
    assign funct  = mips_pkg::funct_e'(instr[5:0]);

    assign imm_sign  = {{16{imm[15]}}, imm};
    assign imm_zero  = {16'd0, imm};
    assign imm_upper = {imm, 16'd0};   // lui

    always_comb begin
        // anything not matched below falls through as a nop
        ctrl         = '0;
        ctrl.rs      = rs;
        ctrl.rt      = rt;
        ctrl.sa      = instr[10:6];
        ctrl.index   = instr[25:0];
        ctrl.alu_op  = mips_pkg::alu_none;
        ctrl.br_kind = mips_pkg::br_seq;

        case (opcode)
            mips_pkg::op_special: begin
                case (funct)
                    mips_pkg::fn_addu,
                    mips_pkg::fn_subu,
                    mips_pkg::fn_and_f,
                    mips_pkg::fn_or_f,
                    mips_pkg::fn_xor_f,
                    mips_pkg::fn_slt: begin
                        ctrl.dest      = rd;
                        ctrl.use_rs    = 1'b1;
                        ctrl.use_rt    = 1'b1;
                        ctrl.reg_write = 1'b1;
                    end
                    mips_pkg::fn_sll,
                    mips_pkg::fn_srl: begin
                        ctrl.dest        = rd;
                        ctrl.use_rt      = 1'b1;   // shifts rt by sa
                        ctrl.alu_a_is_sa = 1'b1;
                        ctrl.reg_write   = 1'b1;
                    end
                    mips_pkg::fn_jr: begin
                        ctrl.use_rs  = 1'b1;
                        ctrl.br_kind = mips_pkg::br_jump_reg;
                    end
                    default: ;
                endcase

                case (funct)
                    mips_pkg::fn_addu:  ctrl.alu_op = mips_pkg::alu_add;
                    mips_pkg::fn_subu:  ctrl.alu_op = mips_pkg::alu_sub;
                    mips_pkg::fn_and_f: ctrl.alu_op = mips_pkg::alu_and_op;
                    mips_pkg::fn_or_f:  ctrl.alu_op = mips_pkg::alu_or_op;
                    mips_pkg::fn_xor_f: ctrl.alu_op = mips_pkg::alu_xor_op;
                    mips_pkg::fn_slt:   ctrl.alu_op = mips_pkg::alu_slt;
                    mips_pkg::fn_sll:   ctrl.alu_op = mips_pkg::alu_sll;
                    mips_pkg::fn_srl:   ctrl.alu_op = mips_pkg::alu_srl;
                    default:            ctrl.alu_op = mips_pkg::alu_none;
                endcase
            end

            mips_pkg::op_addiu,
            mips_pkg::op_andi,
            mips_pkg::op_ori: begin
                ctrl.dest         = rt;
                ctrl.use_rs       = 1'b1;
                ctrl.alu_b_is_imm = 1'b1;
                ctrl.reg_write    = 1'b1;
                if (opcode == mips_pkg::op_addiu) begin
                    ctrl.imm_ext = imm_sign;
                    ctrl.alu_op  = mips_pkg::alu_add;
                end else begin
                    ctrl.imm_ext = imm_zero;   // logical ops zero-extend
                    ctrl.alu_op  = (opcode == mips_pkg::op_andi) ?
                                   mips_pkg::alu_and_op : mips_pkg::alu_or_op;
                end
            end

            mips_pkg::op_lui: begin
                ctrl.dest         = rt;
                ctrl.imm_ext      = imm_upper;
                ctrl.alu_b_is_imm = 1'b1;
                ctrl.alu_op       = mips_pkg::alu_lui;
                ctrl.reg_write    = 1'b1;
            end

            mips_pkg::op_lw: begin
                ctrl.dest         = rt;
                ctrl.imm_ext      = imm_sign;
                ctrl.use_rs       = 1'b1;
                ctrl.alu_b_is_imm = 1'b1;
                ctrl.alu_op       = mips_pkg::alu_add;   // address
                ctrl.mem_read     = 1'b1;
                ctrl.reg_write    = 1'b1;
            end

            mips_pkg::op_sw: begin
                ctrl.imm_ext      = imm_sign;
                ctrl.use_rs       = 1'b1;
                ctrl.use_rt       = 1'b1;   // store data
                ctrl.alu_b_is_imm = 1'b1;
                ctrl.alu_op       = mips_pkg::alu_add;
                ctrl.mem_write    = 1'b1;
            end

            mips_pkg::op_beq,
            mips_pkg::op_bne: begin
                ctrl.imm_ext = imm_sign;
                ctrl.use_rs  = 1'b1;
                ctrl.use_rt  = 1'b1;
                ctrl.br_kind = (opcode == mips_pkg::op_beq) ?
                               mips_pkg::br_beq : mips_pkg::br_bne;
            end

            mips_pkg::op_j: ctrl.br_kind = mips_pkg::br_jump;

            mips_pkg::op_jal: begin
                ctrl.br_kind   = mips_pkg::br_jump;
                ctrl.dest      = 5'(mips_pkg::link_reg);
                ctrl.reg_write = 1'b1;   // link value is nnpc
            end

            default: ;
        endcase
    end

endmodule

`default_nettype wire

// ==== hdl/reg_file.sv ====
// general purpose register file
// 32 x 32, byte-lane writes from writeback, two async read ports
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  wire                       clk,
    input  wire                       rst_n,
    input  wire mips_pkg::wb_write_t  wr,
    input  wire [4:0]                 raddr_a,
    input  wire [4:0]                 raddr_b,
    output logic [31:0]               rdata_a,
    output logic [31:0]               rdata_b
);

    logic [31:0] regs [0:mips_pkg::reg_count-1];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < mips_pkg::reg_count; i++) begin
                regs[i] <= '0;
            end
        end else if (wr.wnum != 5'd0) begin   // r0 stays zero
            for (int b = 0; b < 4; b++) begin
                if (wr.wen[b]) begin
                    regs[wr.wnum][8*b +: 8] <= wr.wdata[8*b +: 8];
                end
            end
        end
    end

    // no write-through, the hazard check holds readers until wb retires
    assign rdata_a = (raddr_a == 5'd0) ? 32'd0 : regs[raddr_a];
    assign rdata_b = (raddr_b == 5'd0) ? 32'd0 : regs[raddr_b];

endmodule

`default_nettype wire

// ==== hdl/mips_pkg.sv ====
// shared definitions for the decode stage
// constants, opcode / funct / alu-op / next-pc enums
// bundle structs between fetch, decode, execute and writeback
`default_nettype none

package mips_pkg;

    localparam int reg_count = 32;   // architectural registers
    localparam int link_reg  = 31;   // jal destination

    // ------------------------------------------------------------------------
    // encodings
    // ------------------------------------------------------------------------
    typedef enum logic [5:0] {
        op_special = 6'h00,
        op_j       = 6'h02,
        op_jal     = 6'h03,
        op_beq     = 6'h04,
        op_bne     = 6'h05,
        op_addiu   = 6'h09,
        op_andi    = 6'h0c,
        op_ori     = 6'h0d,
        op_lui     = 6'h0f,
        op_lw      = 6'h23,
        op_sw      = 6'h2b
    } opcode_e;

    // function field of special opcode
    typedef enum logic [5:0] {
        fn_sll   = 6'h00,
        fn_srl   = 6'h02,
        fn_jr    = 6'h08,
        fn_addu  = 6'h21,
        fn_subu  = 6'h23,
        fn_and_f = 6'h24,
        fn_or_f  = 6'h25,
        fn_xor_f = 6'h26,
        fn_slt   = 6'h2a
    } funct_e;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_and_op, alu_or_op, alu_xor_op,
        alu_slt, alu_sll, alu_srl, alu_lui, alu_none
    } alu_op_e;

    typedef enum logic [2:0] {
        br_seq, br_beq, br_bne, br_jump, br_jump_reg
    } br_kind_e;

    // ------------------------------------------------------------------------
    // bundles
    // ------------------------------------------------------------------------
    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] npc;
        logic [31:0] nnpc;    // link value for jal
        logic [31:0] instr;
    } fetch_bundle_t;

    typedef struct packed {
        logic [31:0] wdata;
        logic [3:0]  wen;     // byte lanes
        logic [4:0]  wnum;
    } wb_write_t;

    typedef struct packed {
        logic       writes;
        logic [4:0] wnum;
    } stage_write_t;

    typedef struct packed {
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  dest;
        logic [31:0] imm_ext;
        logic [4:0]  sa;
        logic [25:0] index;
        alu_op_e     alu_op;
        br_kind_e    br_kind;
        logic        use_rs;
        logic        use_rt;
        logic        alu_a_is_sa;
        logic        alu_b_is_imm;
        logic        mem_read;
        logic        mem_write;
        logic        reg_write;
    } decode_ctrl_t;

    typedef struct packed {
        logic [31:0]  pc;
        logic [31:0]  nnpc;
        logic [31:0]  alu_a;
        logic [31:0]  alu_b;
        logic [31:0]  store_data;
        alu_op_e      alu_op;
        logic         mem_read;
        logic         mem_write;
        stage_write_t dest;
    } exe_bundle_t;

endpackage

`default_nettype wire
